//--- ooo_pkg.sv
`default_nettype none

package ooo_pkg;

	//////////////////////////////////////////////////
	// Machine sizes
	//////////////////////////////////////////////////
	localparam int NUM_REGS  = 8;
	localparam int RS_DEPTH  = 4; // Slots per station
	localparam int ROB_DEPTH = 16;
	localparam int IMM_BITS  = 5;

	typedef logic [15:0] word_t;
	typedef logic [15:0] pc_t;
	typedef logic [2:0]  reg_idx_t;
	typedef logic [3:0]  tag_t; // Reorder buffer slot

	// Top five bits of the instruction word
	typedef enum logic [4:0] {
		ADD_IMM = 5'b00000,
		ADD_REG = 5'b00001,
		SUB_IMM = 5'b00010,
		SUB_REG = 5'b00011,
		LD_REG  = 5'b10100,
		LD_PC   = 5'b10101,
		ST_REG  = 5'b10110,
		ST_PC   = 5'b10111
	} opcode_e;

	typedef enum logic {
		ALU_ADD = 1'b0,
		ALU_SUB = 1'b1
	} alu_op_e;

	// Value when ready, else tag in the low bits
	typedef struct packed {
		logic  ready;
		word_t data;
	} operand_t;

	typedef struct packed {
		logic     valid;
		alu_op_e  op;
		reg_idx_t dest;
		operand_t src0;
		operand_t src1;
		pc_t      pc;
	} dispatch_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		word_t value;
	} cdb_t;

	typedef struct packed {
		logic     valid;
		reg_idx_t dest;
		word_t    value;
	} commit_t;

endpackage

`default_nettype wire

//--- front_end.sv
`default_nettype none

module front_end
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      stall,
	input  word_t     instr,
	output pc_t       fetch_pc,
	output dispatch_t disp
);

	opcode_e   opcode;
	word_t     imm;
	dispatch_t dec;

	assign opcode = opcode_e'(instr[15:11]);
	assign imm = {{($bits(word_t) - IMM_BITS){instr[IMM_BITS-1]}}, instr[IMM_BITS-1:0]};

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////
	always_comb begin
		dec = '0;
		dec.pc = fetch_pc;
		dec.dest = instr[10:8];
		dec.src0.data = word_t'(instr[7:5]); // Raw register number, resolved later
		case (opcode)
			ADD_IMM: begin
				dec.valid = 1'b1;
				dec.op = ALU_ADD;
				dec.src1.ready = 1'b1;
				dec.src1.data = imm;
			end
			ADD_REG: begin
				dec.valid = 1'b1;
				dec.op = ALU_ADD;
				dec.src1.data = word_t'(instr[2:0]);
			end
			SUB_IMM: begin
				dec.valid = 1'b1;
				dec.op = ALU_SUB;
				dec.src1.ready = 1'b1;
				dec.src1.data = imm;
			end
			SUB_REG: begin
				dec.valid = 1'b1;
				dec.op = ALU_SUB;
				dec.src1.data = word_t'(instr[2:0]);
			end
			default: begin
				dec.valid = 1'b0; // Loads, stores and unused opcodes are no-ops
			end
		endcase
	end

	// Record and PC both hold while the core is stalled
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_pc <= '0;
			disp.valid <= 1'b0;
		end else if (!stall) begin
			fetch_pc <= fetch_pc + 1'b1;
			disp <= dec;
		end
	end

	a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(fetch_pc));

endmodule

`default_nettype wire

//--- rename_table.sv
`default_nettype none

module rename_table
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t disp,
	input  logic      dispatch_fire,
	input  tag_t      alloc_tag,
	input  cdb_t      cdb0,
	input  cdb_t      cdb1,
	output operand_t  src0,
	output operand_t  src1
);

	word_t                value [NUM_REGS];
	tag_t                 tag   [NUM_REGS];
	logic [NUM_REGS-1:0]  busy; // Waiting on tag
	reg_idx_t             rs0;
	reg_idx_t             rs1;

	function automatic operand_t resolve(operand_t op, logic pend, word_t v, tag_t t,
			cdb_t c0, cdb_t c1);
		operand_t res;
		res = op;
		if (!op.ready) begin
			res.ready = 1'b1;
			if (!pend)
				res.data = v;
			else if (c0.valid && c0.tag == t)
				res.data = c0.value; // Same-cycle bypass
			else if (c1.valid && c1.tag == t)
				res.data = c1.value;
			else begin
				res.ready = 1'b0;
				res.data = word_t'(t);
			end
		end
		return res;
	endfunction

	assign rs0 = disp.src0.data[$bits(reg_idx_t)-1:0];
	assign rs1 = disp.src1.data[$bits(reg_idx_t)-1:0];
	assign src0 = resolve(disp.src0, busy[rs0], value[rs0], tag[rs0], cdb0, cdb1);
	assign src1 = resolve(disp.src1, busy[rs1], value[rs1], tag[rs1], cdb0, cdb1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= '0;
			for (int i = 0; i < NUM_REGS; i++) begin
				value[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_REGS; i++) begin
				if (busy[i] && cdb0.valid && cdb0.tag == tag[i]) begin
					value[i] <= cdb0.value;
					busy[i] <= 1'b0;
				end
				if (busy[i] && cdb1.valid && cdb1.tag == tag[i]) begin
					value[i] <= cdb1.value;
					busy[i] <= 1'b0;
				end
			end
			if (dispatch_fire) begin // Claim overrides a capture
				busy[disp.dest] <= 1'b1;
				tag[disp.dest] <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

//--- alu_station.sv
`default_nettype none

module alu_station
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t entry_in,
	input  logic      accept,
	input  cdb_t      cdb0,
	input  cdb_t      cdb1,
	input  tag_t      tag_in,
	output logic      full,
	output cdb_t      result
);

	logic [RS_DEPTH-1:0] busy;
	logic [RS_DEPTH-1:0] ready;
	logic [RS_DEPTH-1:0] free_oh;
	logic [RS_DEPTH-1:0] issue_oh;
	alu_op_e             op   [RS_DEPTH];
	operand_t            opa  [RS_DEPTH];
	operand_t            opb  [RS_DEPTH];
	tag_t                dtag [RS_DEPTH];
	logic                write_en;
	alu_op_e             sel_op;
	word_t               sel_a;
	word_t               sel_b;
	tag_t                sel_tag;

	// Operand wake-up from either broadcast
	function automatic operand_t wake(operand_t o, cdb_t c0, cdb_t c1);
		operand_t w;
		w = o;
		if (!o.ready && c0.valid && c0.tag == o.data[$bits(tag_t)-1:0]) begin
			w.ready = 1'b1;
			w.data = c0.value;
		end
		if (!o.ready && c1.valid && c1.tag == o.data[$bits(tag_t)-1:0]) begin
			w.ready = 1'b1;
			w.data = c1.value;
		end
		return w;
	endfunction

	always_comb begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			ready[i] = busy[i] && opa[i].ready && opb[i].ready;
		end
	end

	assign full = &busy;
	assign write_en = accept && entry_in.valid;
	assign free_oh = ~busy & (busy + 1'b1); // Lowest empty slot
	assign issue_oh = ready & (~ready + 1'b1); // Lowest ready slot

	always_comb begin
		sel_op = ALU_ADD;
		sel_a = '0;
		sel_b = '0;
		sel_tag = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (issue_oh[i]) begin
				sel_op = op[i];
				sel_a = opa[i].data;
				sel_b = opb[i].data;
				sel_tag = dtag[i];
			end
		end
	end

	//////////////////////////////////////////////////
	// Issue and execute
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		result.tag <= sel_tag;
		result.value <= (sel_op == ALU_SUB) ? sel_a - sel_b : sel_a + sel_b;
		if (!rst_n) begin
			busy <= '0;
			result.valid <= 1'b0;
		end else begin
			busy <= (busy & ~issue_oh) | (write_en ? free_oh : '0);
			result.valid <= |issue_oh;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (write_en && free_oh[i]) begin
				op[i] <= entry_in.op;
				opa[i] <= entry_in.src0;
				opb[i] <= entry_in.src1;
				dtag[i] <= tag_in;
			end else begin
				opa[i] <= wake(opa[i], cdb0, cdb1);
				opb[i] <= wake(opb[i], cdb0, cdb1);
			end
		end
	end

	a_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
		accept |-> !full);

	a_result_source: assert property (@(posedge clk) disable iff (!rst_n)
		result.valid |-> $past(busy != '0));

endmodule

`default_nettype wire

//--- reorder_buffer.sv
`default_nettype none

module reorder_buffer
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     alloc,
	input  reg_idx_t alloc_dest,
	output tag_t     alloc_tag,
	output logic     full,
	input  cdb_t     cdb0,
	input  cdb_t     cdb1,
	output commit_t  commit
);

	reg_idx_t                   dest  [ROB_DEPTH];
	word_t                      value [ROB_DEPTH];
	logic [ROB_DEPTH-1:0]       busy; // Allocated, not yet retired
	logic [ROB_DEPTH-1:0]       done; // Result written
	tag_t                       head;
	tag_t                       tail;
	logic [$clog2(ROB_DEPTH):0] count;
	logic                       retire;

	assign alloc_tag = tail;
	assign full = (count == ROB_DEPTH);
	assign retire = busy[head] && done[head];

	//////////////////////////////////////////////////
	// Pointers and commit
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		commit.dest <= dest[head];
		commit.value <= value[head];
		if (!rst_n) begin
			busy <= '0;
			head <= '0;
			tail <= '0;
			count <= '0;
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= retire;
			if (retire) begin
				busy[head] <= 1'b0;
				head <= head + 1'b1;
			end
			if (alloc) begin
				busy[tail] <= 1'b1;
				tail <= tail + 1'b1;
			end
			case ({alloc, retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry payload
	always_ff @(posedge clk) begin
		if (alloc) begin
			dest[tail] <= alloc_dest;
			done[tail] <= 1'b0;
		end
		if (cdb0.valid) begin
			value[cdb0.tag] <= cdb0.value;
			done[cdb0.tag] <= 1'b1;
		end
		if (cdb1.valid) begin
			value[cdb1.tag] <= cdb1.value;
			done[cdb1.tag] <= 1'b1;
		end
	end

	a_cdb0_alloc: assert property (@(posedge clk) disable iff (!rst_n)
		cdb0.valid |-> busy[cdb0.tag]);

	a_cdb1_alloc: assert property (@(posedge clk) disable iff (!rst_n)
		cdb1.valid |-> busy[cdb1.tag]);

endmodule

`default_nettype wire

//--- arch_regfile.sv
`default_nettype none

module arch_regfile
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  commit_t  commit,
	input  reg_idx_t dbg_addr,
	output word_t    dbg_value
);

	word_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (commit.valid) begin
			regs[commit.dest] <= commit.value;
		end
	end

	// Forward the value retiring this cycle
	assign dbg_value = (commit.valid && commit.dest == dbg_addr) ? commit.value
		: regs[dbg_addr];

endmodule

`default_nettype wire

//--- ooo_core.sv
`default_nettype none

module ooo_core
	import ooo_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  word_t    instr,
	output pc_t      fetch_pc,
	output logic     stall,
	output commit_t  commit,
	input  reg_idx_t dbg_addr,
	output word_t    dbg_value
);

	dispatch_t disp;
	dispatch_t disp_rs; // Record with renamed operands
	operand_t  src0;
	operand_t  src1;
	cdb_t      cdb0;
	cdb_t      cdb1;
	tag_t      alloc_tag;
	logic      rob_full;
	logic      full0;
	logic      full1;
	logic      sel0;
	logic      sel_full;
	logic      dispatch_fire;

	//////////////////////////////////////////////////
	// Dispatch steering
	//////////////////////////////////////////////////
	assign sel0 = disp.pc[0]; // Odd PC goes to station 0
	assign sel_full = sel0 ? full0 : full1;
	assign stall = disp.valid && (rob_full || sel_full);
	assign dispatch_fire = disp.valid && !stall;

	always_comb begin
		disp_rs = disp;
		disp_rs.src0 = src0;
		disp_rs.src1 = src1;
	end

	front_end front_end_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.instr    (instr),
		.fetch_pc (fetch_pc),
		.disp     (disp)
	);

	rename_table rename_table_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.disp          (disp),
		.dispatch_fire (dispatch_fire),
		.alloc_tag     (alloc_tag),
		.cdb0          (cdb0),
		.cdb1          (cdb1),
		.src0          (src0),
		.src1          (src1)
	);

	alu_station station0_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.entry_in (disp_rs),
		.accept   (dispatch_fire && sel0),
		.cdb0     (cdb0),
		.cdb1     (cdb1),
		.tag_in   (alloc_tag),
		.full     (full0),
		.result   (cdb0)
	);

	alu_station station1_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.entry_in (disp_rs),
		.accept   (dispatch_fire && !sel0),
		.cdb0     (cdb0),
		.cdb1     (cdb1),
		.tag_in   (alloc_tag),
		.full     (full1),
		.result   (cdb1)
	);

	reorder_buffer reorder_buffer_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.alloc      (dispatch_fire),
		.alloc_dest (disp.dest),
		.alloc_tag  (alloc_tag),
		.full       (rob_full),
		.cdb0       (cdb0),
		.cdb1       (cdb1),
		.commit     (commit)
	);

	arch_regfile arch_regfile_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.commit    (commit),
		.dbg_addr  (dbg_addr),
		.dbg_value (dbg_value)
	);

endmodule

`default_nettype wire

//--- tb_ooo_core.sv
`default_nettype none

module tb_ooo_core
	import ooo_pkg::*;
();

	localparam int    NUM_TESTS    = 4;
	localparam int    PROG_ROWS    = 64;
	localparam int    DRAIN_MARGIN = 80; // Reset, debug reads and settle
	localparam word_t NOP_WORD     = 16'hF800; // Opcode 11111

	typedef struct {
		string name;
		int    start;
		int    len;
		bit    expect_stall;
	} test_row_t;

	logic     clk;
	logic     rst_n;
	word_t    instr;
	pc_t      fetch_pc;
	logic     stall;
	commit_t  commit;
	reg_idx_t dbg_addr;
	word_t    dbg_value;

	test_row_t tests [NUM_TESTS];
	word_t     prog [PROG_ROWS]; // Row index is the PC
	word_t     model_regs [NUM_REGS];
	commit_t   exp_q [$];
	string     cur_name;
	int        cur_start;
	int        cur_len;
	int        commit_idx;
	bit        stall_seen;
	pc_t       prev_pc;
	logic      prev_stall;
	bit        pc_tracked;
	int        errors;
	int        failed_tests;
	int        cycles;
	int        cycle_limit;
	int        seed;

	ooo_core ooo_core_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.fetch_pc  (fetch_pc),
		.stall     (stall),
		.commit    (commit),
		.dbg_addr  (dbg_addr),
		.dbg_value (dbg_value)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Program construction and reference model
	//////////////////////////////////////////////////
	function automatic word_t imm_instr(opcode_e op, int rd, int rs, int imm);
		return {op, 3'(rd), 3'(rs), 5'(imm)};
	endfunction

	function automatic word_t reg_instr(opcode_e op, int rd, int rs, int rt);
		return {op, 3'(rd), 3'(rs), 2'b00, 3'(rt)};
	endfunction

	function automatic int rand_imm();
		return $random(seed) & 32'h1f;
	endfunction

	task automatic build_programs();
		for (int i = 0; i < PROG_ROWS; i++)
			prog[i] = NOP_WORD;
		for (int k = 0; k < 8; k++) begin // r0 is never written here
			prog[2 + k] = imm_instr((k % 2) ? SUB_IMM : ADD_IMM, (k % 7) + 1, 0, rand_imm());
		end
		prog[12] = imm_instr(ADD_IMM, 1, 0, 5);
		prog[13] = imm_instr(SUB_IMM, 2, 0, 3);
		prog[14] = reg_instr(ADD_REG, 3, 1, 2);
		prog[15] = reg_instr(SUB_REG, 4, 3, 1);
		prog[16] = reg_instr(ADD_REG, 3, 4, 3); // WAW on r3
		prog[17] = reg_instr(SUB_REG, 5, 3, 2);
		prog[18] = imm_instr(ADD_IMM, 1, 1, rand_imm());
		prog[19] = reg_instr(ADD_REG, 6, 5, 1);
		prog[20] = reg_instr(SUB_REG, 6, 6, 4);
		prog[21] = reg_instr(ADD_REG, 7, 6, 6);
		prog[22] = reg_instr(SUB_REG, 2, 7, 3);
		prog[23] = reg_instr(ADD_REG, 0, 2, 7);
		// Serial chain on r1, long enough to back up a station
		for (int k = 0; k < 24; k++) begin
			prog[26 + k] = imm_instr((k % 2) ? SUB_IMM : ADD_IMM, 1, 1, rand_imm());
		end
		prog[52] = imm_instr(LD_REG, 1, 2, 4);
		prog[53] = imm_instr(ADD_IMM, 1, 0, rand_imm());
		prog[54] = imm_instr(ST_REG, 0, 1, 2);
		prog[55] = imm_instr(SUB_IMM, 2, 1, rand_imm());
		prog[56] = imm_instr(LD_PC, 2, 0, 9);
		prog[57] = reg_instr(ADD_REG, 3, 2, 1);
		prog[58] = imm_instr(ST_PC, 3, 3, 1);
		prog[59] = imm_instr(LD_REG, 3, 1, 0);
		prog[60] = reg_instr(SUB_REG, 4, 3, 2);
		prog[61] = imm_instr(SUB_IMM, 5, 4, rand_imm());
	endtask

	// In-order ISA: 16-bit wrap, immediates sign-extended from bit 4
	task automatic run_model(int start, int len);
		word_t   w;
		word_t   a;
		word_t   b;
		commit_t c;
		exp_q.delete();
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		for (int i = start; i < start + len; i++) begin
			w = prog[i];
			if (w[15:13] == 3'b000) begin // Opcodes 00000 to 00011 only
				a = model_regs[w[7:5]];
				b = w[11] ? model_regs[w[2:0]] : {{11{w[4]}}, w[4:0]};
				c.valid = 1'b1;
				c.dest = w[10:8];
				c.value = w[12] ? a - b : a + b;
				exp_q.push_back(c);
				model_regs[c.dest] = c.value;
			end
		end
	endtask

	function automatic word_t word_at(pc_t pc);
		if (pc >= cur_start && pc < cur_start + cur_len)
			return prog[pc];
		return NOP_WORD;
	endfunction

	task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Instruction memory, monitor, watchdog
	//////////////////////////////////////////////////
	always @(posedge clk) begin
		#1;
		instr = word_at(fetch_pc);
	end

	always @(negedge clk) begin
		if (rst_n && stall)
			stall_seen = 1'b1;
		if (rst_n && commit.valid) begin
			if (commit_idx < exp_q.size()) begin
				check($sformatf("commit %0d dest", commit_idx), exp_q[commit_idx].dest,
					commit.dest);
				check($sformatf("commit %0d value", commit_idx), exp_q[commit_idx].value,
					commit.value);
			end else begin
				$display("ERROR %s: extra commit past the end of the program, r%0d = %h",
					cur_name, commit.dest, commit.value);
				errors++;
			end
			commit_idx++;
		end
	end

	// Fetch advances by one per cycle, holds after a stalled cycle
	always @(negedge clk) begin
		if (!rst_n) begin
			pc_tracked = 1'b0;
		end else begin
			if (pc_tracked)
				check("fetch_pc", prev_stall ? prev_pc : pc_t'(prev_pc + 1), fetch_pc);
			prev_pc = fetch_pc;
			prev_stall = stall;
			pc_tracked = 1'b1;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout in test %s after %0d cycles", cur_name, cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// Committed registers are zero throughout reset
	task automatic apply_reset();
		rst_n = 1'b0;
		@(posedge clk);
		for (int r = 0; r < NUM_REGS; r++) begin
			@(posedge clk);
			#1 dbg_addr = reg_idx_t'(r);
			@(negedge clk);
			check($sformatf("reset r%0d", r), 16'h0, dbg_value);
		end
		@(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		check("reset commit valid", 1'b0, commit.valid);
		check("reset stall", 1'b0, stall);
	endtask

	task automatic check_regs();
		for (int r = 0; r < NUM_REGS; r++) begin
			@(posedge clk);
			#1 dbg_addr = reg_idx_t'(r);
			@(negedge clk);
			check($sformatf("final r%0d", r), model_regs[r], dbg_value);
		end
	endtask

	initial begin
		int start_errors;
		rst_n = 1'b0;
		instr = NOP_WORD;
		dbg_addr = '0;
		seed = 35890;
		errors = 0;
		failed_tests = 0;
		cycles = 0;
		commit_idx = 0;
		stall_seen = 1'b0;
		prev_pc = '0;
		prev_stall = 1'b0;
		pc_tracked = 1'b0;
		cur_start = 0;
		cur_len = 0;
		tests[0] = '{"imm_independent", 2, 8, 1'b0};
		tests[1] = '{"dependency_chains", 12, 12, 1'b0};
		tests[2] = '{"long_chain_stall", 26, 24, 1'b1};
		tests[3] = '{"memory_noops", 52, 10, 1'b0};
		cycle_limit = 0;
		for (int t = 0; t < NUM_TESTS; t++)
			cycle_limit += 12 * tests[t].len + tests[t].start + DRAIN_MARGIN;
		build_programs();

		for (int t = 0; t < NUM_TESTS; t++) begin
			rst_n = 1'b0;
			cur_name = tests[t].name;
			cur_start = tests[t].start;
			cur_len = tests[t].len;
			run_model(cur_start, cur_len);
			commit_idx = 0;
			stall_seen = 1'b0;
			start_errors = errors;
			apply_reset();
			while (commit_idx < exp_q.size())
				@(posedge clk);
			repeat (4) @(posedge clk); // Window for stray commits
			check_regs();
			check("commit count", exp_q.size(), commit_idx);
			if (tests[t].expect_stall)
				check("stall raised", 1, stall_seen);
			if (errors == start_errors) begin
				$display("%s: ok, %0d commits", cur_name, commit_idx);
			end else begin
				$display("%s: FAILED, %0d errors", cur_name, errors - start_errors);
				failed_tests++;
			end
		end

		$display("Tests %0d, failed %0d, mismatches %0d", NUM_TESTS, failed_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
ooo_pkg.sv
front_end.sv
rename_table.sv
alu_station.sv
reorder_buffer.sv
arch_regfile.sv
ooo_core.sv
tb_ooo_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ooo_core
FILE_LIST = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
